// ==== btb.f ====
logic/btb_pkg.sv
logic/btb_way_array.sv
logic/btb_plru_table.sv
logic/btb_hit_select.sv
logic/btb.sv
tests/btb_tb.sv

// ==== logic/btb.sv ====
// Branch target buffer top
`timescale 1ns/100ps
`default_nettype none

module btb (
    input  logic                  CLK,
    input  logic                  rst,

    // arch state
    input  btb_pkg::asid_t        arch_asid,

    // read request
    input  logic                  read_req_valid,
    input  btb_pkg::fetch_idx_t   read_req_fetch_idx,

    // read response
    input  btb_pkg::pc38_t        read_resp_pc38,
    output logic                  read_resp_hit,
    output btb_pkg::btb_way_t     read_resp_hit_way,
    output btb_pkg::fetch_lane_t  read_resp_hit_lane,
    output logic                  read_resp_double_hit,
    output btb_pkg::btb_info_t    read_resp_btb_info,

    // update
    input  logic                  update_valid,
    input  btb_pkg::pc38_t        update_pc38,
    input  btb_pkg::btb_info_t    update_btb_info,
    input  logic                  update_hit,
    input  btb_pkg::btb_way_t     update_hit_way
);

    // ------------------------------------------------
    // signals

    btb_pkg::btb_idx_t     read_index;
    btb_pkg::btb_tag_t     resp_tag;
    btb_pkg::fetch_lane_t  resp_lane;

    btb_pkg::btb_entry_t   entry_0;
    btb_pkg::btb_entry_t   entry_1;
    logic                  entry_valid_0;
    logic                  entry_valid_1;

    btb_pkg::btb_idx_t     update_index;
    btb_pkg::btb_entry_t   write_entry;
    btb_pkg::btb_way_t     write_way;
    logic                  write_valid_0;
    logic                  write_valid_1;

    // ------------------------------------------------
    // hashing

    always_comb begin
        read_index = btb_pkg::index_hash(read_req_fetch_idx, arch_asid);
        resp_tag   = btb_pkg::tag_hash(read_resp_pc38, arch_asid);
        resp_lane  = btb_pkg::fetch_lane_bits(read_resp_pc38);

        update_index = btb_pkg::index_hash(btb_pkg::fetch_idx_bits(update_pc38), arch_asid);
        // same entry goes to both ways, only one strobe fires
        write_entry.tag  = btb_pkg::tag_hash(update_pc38, arch_asid);
        write_entry.lane = btb_pkg::fetch_lane_bits(update_pc38);
        write_entry.info = update_btb_info;
    end

    // way decode
    assign write_valid_0 = update_valid & (write_way == 1'b0);
    assign write_valid_1 = update_valid & (write_way == 1'b1);

    // ------------------------------------------------
    // way arrays

    btb_way_array way_0 (
        .CLK              (CLK),
        .rst              (rst),
        .read_valid       (read_req_valid),
        .read_index       (read_index),
        .read_entry       (entry_0),
        .read_entry_valid (entry_valid_0),
        .write_valid      (write_valid_0),
        .write_index      (update_index),
        .write_entry      (write_entry)
    );

    btb_way_array way_1 (
        .CLK              (CLK),
        .rst              (rst),
        .read_valid       (read_req_valid),
        .read_index       (read_index),
        .read_entry       (entry_1),
        .read_entry_valid (entry_valid_1),
        .write_valid      (write_valid_1),
        .write_index      (update_index),
        .write_entry      (write_entry)
    );

    // ------------------------------------------------
    // plru and hit selection

    btb_plru_table plru_table (
        .CLK            (CLK),
        .rst            (rst),
        .update_valid   (update_valid),
        .update_index   (update_index),
        .update_hit     (update_hit),
        .update_hit_way (update_hit_way),
        .write_way      (write_way)
    );

    btb_hit_select hit_select (
        .entry_0    (entry_0),
        .valid_0    (entry_valid_0),
        .entry_1    (entry_1),
        .valid_1    (entry_valid_1),
        .resp_tag   (resp_tag),
        .resp_lane  (resp_lane),
        .hit        (read_resp_hit),
        .hit_way    (read_resp_hit_way),
        .hit_lane   (read_resp_hit_lane),
        .double_hit (read_resp_double_hit),
        .info       (read_resp_btb_info)
    );

endmodule

`default_nettype wire

// ==== logic/btb_hit_select.sv ====
// BTB two-way hit selection
`timescale 1ns/100ps
`default_nettype none

module btb_hit_select (
    input  btb_pkg::btb_entry_t   entry_0,
    input  logic                  valid_0,
    input  btb_pkg::btb_entry_t   entry_1,
    input  logic                  valid_1,

    // from the response pc
    input  btb_pkg::btb_tag_t     resp_tag,
    input  btb_pkg::fetch_lane_t  resp_lane,

    output logic                  hit,
    output btb_pkg::btb_way_t     hit_way,
    output btb_pkg::fetch_lane_t  hit_lane,
    output logic                  double_hit,
    output btb_pkg::btb_info_t    info
);

    logic hit_0;
    logic hit_1;

    // ------------------------------------------------
    // per-way match

    always_comb begin
        // valid, real branch, tag match, lane at or past fetch lane
        hit_0 = valid_0
            & (entry_0.info.action != btb_pkg::ACTION_NONE)
            & (entry_0.tag == resp_tag)
            & (entry_0.lane >= resp_lane);
        hit_1 = valid_1
            & (entry_1.info.action != btb_pkg::ACTION_NONE)
            & (entry_1.tag == resp_tag)
            & (entry_1.lane >= resp_lane);
    end

    assign hit        = hit_0 | hit_1;
    assign double_hit = hit_0 & hit_1;

    // ------------------------------------------------
    // winner mux

    always_comb begin
        // lower lane wins, way 1 on a tie
        if ((hit_1 && !hit_0) || (double_hit && (entry_1.lane <= entry_0.lane))) begin
            hit_way  = 1'b1;
            hit_lane = entry_1.lane;
            info     = entry_1.info;
        end
        else begin
            // also the default when nothing hits
            hit_way  = 1'b0;
            hit_lane = entry_0.lane;
            info     = entry_0.info;
        end
    end

endmodule

`default_nettype wire

// ==== logic/btb_pkg.sv ====
// Branch target buffer definitions
`default_nettype none

package btb_pkg;

    // ------------------------------------------------
    // sizes

    localparam int PC_WIDTH        = 38;
    localparam int ASID_WIDTH      = 9;
    localparam int TARGET_WIDTH    = 32;
    localparam int LOG_BTB_SETS    = 6;
    localparam int LOG_FETCH_LANES = 3;
    localparam int BTB_SETS        = 1 << LOG_BTB_SETS;
    // tag is whatever pc remains above index and lane
    localparam int BTB_TAG_WIDTH   = PC_WIDTH - LOG_BTB_SETS - LOG_FETCH_LANES;

    // ------------------------------------------------
    // basic types

    typedef logic [PC_WIDTH-1:0]        pc38_t;
    typedef logic [LOG_BTB_SETS-1:0]    fetch_idx_t;
    typedef logic [LOG_FETCH_LANES-1:0] fetch_lane_t;
    typedef logic [ASID_WIDTH-1:0]      asid_t;
    typedef logic [LOG_BTB_SETS-1:0]    btb_idx_t;
    typedef logic [BTB_TAG_WIDTH-1:0]   btb_tag_t;
    typedef logic                       btb_way_t;

    // zero action means no branch stored here
    typedef enum logic [2:0] {
        ACTION_NONE   = 3'd0,
        ACTION_BRANCH = 3'd1,
        ACTION_JUMP   = 3'd2,
        ACTION_CALL   = 3'd3,
        ACTION_RETURN = 3'd4
    } btb_action_e;

    typedef struct packed {
        btb_action_e              action;
        logic [TARGET_WIDTH-1:0]  target;
    } btb_info_t;

    typedef struct packed {
        btb_tag_t     tag;
        fetch_lane_t  lane;
        btb_info_t    info;
    } btb_entry_t;

    // ------------------------------------------------
    // pc field pickers and hashes

    function automatic fetch_lane_t fetch_lane_bits(pc38_t pc38);
        return pc38[LOG_FETCH_LANES-1:0];
    endfunction

    function automatic fetch_idx_t fetch_idx_bits(pc38_t pc38);
        return pc38[LOG_FETCH_LANES +: LOG_BTB_SETS];
    endfunction

    function automatic btb_idx_t index_hash(fetch_idx_t fetch_idx, asid_t asid);
        return fetch_idx ^ asid[LOG_BTB_SETS-1:0];
    endfunction

    function automatic btb_tag_t tag_hash(pc38_t pc38, asid_t asid);
        return pc38[PC_WIDTH-1 -: BTB_TAG_WIDTH] ^ btb_tag_t'(asid);
    endfunction

endpackage

`default_nettype wire

// ==== logic/btb_plru_table.sv ====
// BTB pseudo-LRU table
`timescale 1ns/100ps
`default_nettype none

module btb_plru_table (
    input  logic               CLK,
    input  logic               rst,

    input  logic               update_valid,
    input  btb_pkg::btb_idx_t  update_index,
    input  logic               update_hit,
    input  btb_pkg::btb_way_t  update_hit_way,

    output btb_pkg::btb_way_t  write_way
);

    // one bit per set, names the victim way
    logic [btb_pkg::BTB_SETS-1:0]  plru_bits;

    // ------------------------------------------------
    // way choice

    always_comb begin
        if (update_hit) begin
            write_way = update_hit_way;
        end
        else begin
            write_way = plru_bits[update_index];
        end
    end

    // ------------------------------------------------
    // plru update, point at the way not just written

    always_ff @(posedge CLK) begin
        if (rst) begin
            plru_bits <= '0;
        end
        else if (update_valid) begin
            plru_bits[update_index] <= ~write_way;
        end
    end

endmodule

`default_nettype wire

// ==== logic/btb_way_array.sv ====
// BTB single way storage
`timescale 1ns/100ps
`default_nettype none

module btb_way_array (
    input  logic                 CLK,
    input  logic                 rst,

    // read port, data one cycle after strobe
    input  logic                 read_valid,
    input  btb_pkg::btb_idx_t    read_index,
    output btb_pkg::btb_entry_t  read_entry,
    output logic                 read_entry_valid,

    // write port
    input  logic                 write_valid,
    input  btb_pkg::btb_idx_t    write_index,
    input  btb_pkg::btb_entry_t  write_entry
);

    // ------------------------------------------------
    // storage

    btb_pkg::btb_entry_t           entry_mem [btb_pkg::BTB_SETS];
    logic [btb_pkg::BTB_SETS-1:0]  valid_vec;

    // ------------------------------------------------
    // valid bits

    always_ff @(posedge CLK) begin
        if (rst) begin
            valid_vec        <= '0;
            read_entry_valid <= 1'b0;
        end
        else begin
            // read sees the old bit on a same-set write
            if (read_valid) begin
                read_entry_valid <= valid_vec[read_index];
            end
            if (write_valid) begin
                valid_vec[write_index] <= 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // entry array

    always_ff @(posedge CLK) begin
        // output holds between read strobes
        if (read_valid) begin
            read_entry <= entry_mem[read_index];
        end
        if (write_valid) begin
            entry_mem[write_index] <= write_entry;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile the BTB testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module btb_tb -f btb.f -o btb_sim &&
./obj_dir/btb_sim | tee /dev/stderr | grep -q "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tests/btb_tb.sv ====
// BTB directed testbench
`timescale 1ns/100ps
`default_nettype none

module btb_tb;

    localparam int MAX_CYCLES = 2000;

    logic                  CLK;
    logic                  rst;
    btb_pkg::asid_t        arch_asid;
    logic                  read_req_valid;
    btb_pkg::fetch_idx_t   read_req_fetch_idx;
    btb_pkg::pc38_t        read_resp_pc38;
    logic                  read_resp_hit;
    btb_pkg::btb_way_t     read_resp_hit_way;
    btb_pkg::fetch_lane_t  read_resp_hit_lane;
    logic                  read_resp_double_hit;
    btb_pkg::btb_info_t    read_resp_btb_info;
    logic                  update_valid;
    btb_pkg::pc38_t        update_pc38;
    btb_pkg::btb_info_t    update_btb_info;
    logic                  update_hit;
    btb_pkg::btb_way_t     update_hit_way;

    int           errors;
    int           checks;
    int           cycles = 0;
    integer       seed;
    // reference copy of the victim bit per set
    logic [63:0]  plru_model;

    btb i_dut (
        .CLK                  (CLK),
        .rst                  (rst),
        .arch_asid            (arch_asid),
        .read_req_valid       (read_req_valid),
        .read_req_fetch_idx   (read_req_fetch_idx),
        .read_resp_pc38       (read_resp_pc38),
        .read_resp_hit        (read_resp_hit),
        .read_resp_hit_way    (read_resp_hit_way),
        .read_resp_hit_lane   (read_resp_hit_lane),
        .read_resp_double_hit (read_resp_double_hit),
        .read_resp_btb_info   (read_resp_btb_info),
        .update_valid         (update_valid),
        .update_pc38          (update_pc38),
        .update_btb_info      (update_btb_info),
        .update_hit           (update_hit),
        .update_hit_way       (update_hit_way)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------------------------
    // reference model

    // set index is the fetch index xor the low asid bits
    function automatic btb_pkg::btb_idx_t model_index(btb_pkg::pc38_t pc, btb_pkg::asid_t asid);
        return pc[8:3] ^ asid[5:0];
    endfunction

    function automatic btb_pkg::pc38_t make_pc(logic [28:0] high, logic [5:0] idx,
                                               logic [2:0] lane);
        return {high, idx, lane};
    endfunction

    function automatic btb_pkg::btb_info_t make_info(btb_pkg::btb_action_e action);
        btb_pkg::btb_info_t info;
        info.action = action;
        info.target = $random(seed);
        return info;
    endfunction

    // ------------------------------------------------
    // drivers and checkers

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic update_entry(input btb_pkg::pc38_t pc, input btb_pkg::btb_info_t info,
                                input logic hit, input btb_pkg::btb_way_t hit_way,
                                output btb_pkg::btb_way_t way);
        btb_pkg::btb_idx_t idx;
        idx = model_index(pc, arch_asid);
        way = hit ? hit_way : plru_model[idx];
        plru_model[idx] = ~way;
        update_valid    = 1'b1;
        update_pc38     = pc;
        update_btb_info = info;
        update_hit      = hit;
        update_hit_way  = hit_way;
        next_cycle();
        update_valid = 1'b0;
        update_hit   = 1'b0;
    endtask

    // response pc goes out with the request, outputs valid after the next edge
    task automatic read_set(input btb_pkg::pc38_t pc);
        read_req_valid     = 1'b1;
        read_req_fetch_idx = pc[8:3];
        read_resp_pc38     = pc;
        next_cycle();
        read_req_valid = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
                     $time);
            errors++;
        end
    endtask

    task automatic expect_miss();
        check_value("read_resp_hit", 64'(1'b0), 64'(read_resp_hit));
        check_value("read_resp_double_hit", 64'(1'b0), 64'(read_resp_double_hit));
    endtask

    task automatic expect_hit(input btb_pkg::btb_way_t way, input btb_pkg::fetch_lane_t lane,
                              input btb_pkg::btb_info_t info, input logic dbl);
        check_value("read_resp_hit", 64'(1'b1), 64'(read_resp_hit));
        check_value("read_resp_double_hit", 64'(dbl), 64'(read_resp_double_hit));
        check_value("read_resp_hit_way", 64'(way), 64'(read_resp_hit_way));
        check_value("read_resp_hit_lane", 64'(lane), 64'(read_resp_hit_lane));
        check_value("read_resp_btb_info", 64'(info), 64'(read_resp_btb_info));
    endtask

    // ------------------------------------------------
    // tests

    task automatic test_reset_reads();
        for (int i = 0; i < 64; i += 9) begin
            read_set(make_pc(29'h1234, 6'(i), 3'd0));
            expect_miss();
        end
    endtask

    task automatic test_plru_victim();
        btb_pkg::pc38_t      pcs [5];
        btb_pkg::btb_info_t  infos [5];
        btb_pkg::btb_way_t   ways [5];
        btb_pkg::btb_way_t   touch_way;
        for (int i = 0; i < 5; i++) begin
            pcs[i]   = make_pc(29'(32'h100 + i), 6'd5, 3'd2);
            infos[i] = make_info(btb_pkg::ACTION_BRANCH);
        end
        // four new entries alternate ways
        for (int i = 0; i < 4; i++) begin
            update_entry(pcs[i], infos[i], 1'b0, 1'b0, ways[i]);
            read_set(pcs[i]);
            expect_hit(ways[i], 3'd2, infos[i], 1'b0);
        end
        // touch keeps C alive, so E evicts D
        update_entry(pcs[2], infos[2], 1'b1, ways[2], touch_way);
        update_entry(pcs[4], infos[4], 1'b0, 1'b0, ways[4]);
        read_set(pcs[4]);
        expect_hit(ways[4], 3'd2, infos[4], 1'b0);
        read_set(pcs[2]);
        expect_hit(ways[2], 3'd2, infos[2], 1'b0);
        read_set(pcs[3]);
        expect_miss();
    endtask

    task automatic test_lane_match();
        btb_pkg::pc38_t      pc;
        btb_pkg::btb_info_t  info;
        btb_pkg::btb_way_t   way;
        pc   = make_pc(29'h0abcd, 6'd12, 3'd4);
        info = make_info(btb_pkg::ACTION_JUMP);
        update_entry(pc, info, 1'b0, 1'b0, way);
        for (int l = 0; l < 8; l++) begin
            read_set(make_pc(29'h0abcd, 6'd12, 3'(l)));
            if (l <= 4) begin
                expect_hit(way, 3'd4, info, 1'b0);
            end
            else begin
                expect_miss();
            end
        end
    endtask

    task automatic test_double_hit();
        btb_pkg::btb_info_t  info_hi;
        btb_pkg::btb_info_t  info_lo;
        btb_pkg::btb_way_t   way_hi;
        btb_pkg::btb_way_t   way_lo;
        info_hi = make_info(btb_pkg::ACTION_CALL);
        info_lo = make_info(btb_pkg::ACTION_BRANCH);
        update_entry(make_pc(29'h2222, 6'd20, 3'd6), info_hi, 1'b0, 1'b0, way_hi);
        update_entry(make_pc(29'h2222, 6'd20, 3'd2), info_lo, 1'b0, 1'b0, way_lo);
        read_set(make_pc(29'h2222, 6'd20, 3'd0));
        expect_hit(way_lo, 3'd2, info_lo, 1'b1);
        read_set(make_pc(29'h2222, 6'd20, 3'd3));
        expect_hit(way_hi, 3'd6, info_hi, 1'b0);
        // equal lanes, way 1 reported
        update_entry(make_pc(29'h2223, 6'd21, 3'd3), info_hi, 1'b0, 1'b0, way_hi);
        update_entry(make_pc(29'h2223, 6'd21, 3'd3), info_lo, 1'b0, 1'b0, way_lo);
        read_set(make_pc(29'h2223, 6'd21, 3'd1));
        expect_hit(1'b1, 3'd3, (way_lo == 1'b1) ? info_lo : info_hi, 1'b1);
    endtask

    task automatic test_asid();
        btb_pkg::pc38_t      pc;
        btb_pkg::btb_info_t  info;
        btb_pkg::btb_way_t   way;
        pc   = make_pc(29'h3333, 6'd30, 3'd5);
        info = make_info(btb_pkg::ACTION_RETURN);
        update_entry(pc, info, 1'b0, 1'b0, way);
        read_set(pc);
        expect_hit(way, 3'd5, info, 1'b0);
        // same set index, tag differs in asid bit 8
        arch_asid = 9'h1a5;
        read_set(pc);
        expect_miss();
        arch_asid = 9'h0a5;
        read_set(pc);
        expect_hit(way, 3'd5, info, 1'b0);
    endtask

    task automatic test_none_and_rewrite();
        btb_pkg::btb_info_t  info_x;
        btb_pkg::btb_info_t  info_y;
        btb_pkg::btb_info_t  info_new;
        btb_pkg::btb_way_t   way_x;
        btb_pkg::btb_way_t   way_y;
        btb_pkg::btb_way_t   way_tmp;
        update_entry(make_pc(29'h4444, 6'd40, 3'd3), make_info(btb_pkg::ACTION_NONE),
                     1'b0, 1'b0, way_tmp);
        read_set(make_pc(29'h4444, 6'd40, 3'd0));
        expect_miss();
        read_set(make_pc(29'h4444, 6'd40, 3'd3));
        expect_miss();
        info_x   = make_info(btb_pkg::ACTION_BRANCH);
        info_y   = make_info(btb_pkg::ACTION_JUMP);
        info_new = make_info(btb_pkg::ACTION_CALL);
        update_entry(make_pc(29'h5555, 6'd41, 3'd1), info_x, 1'b0, 1'b0, way_x);
        update_entry(make_pc(29'h5555, 6'd41, 3'd5), info_y, 1'b0, 1'b0, way_y);
        update_entry(make_pc(29'h5555, 6'd41, 3'd1), info_new, 1'b1, way_x, way_tmp);
        read_set(make_pc(29'h5555, 6'd41, 3'd0));
        expect_hit(way_x, 3'd1, info_new, 1'b1);
        read_set(make_pc(29'h5555, 6'd41, 3'd2));
        expect_hit(way_y, 3'd5, info_y, 1'b0);
    endtask

    // ------------------------------------------------
    // main sequence

    initial begin
        seed               = 3666;
        errors             = 0;
        checks             = 0;
        plru_model         = '0;
        rst                = 1'b1;
        arch_asid          = 9'h0a5;
        read_req_valid     = 1'b0;
        read_req_fetch_idx = '0;
        read_resp_pc38     = '0;
        update_valid       = 1'b0;
        update_pc38        = '0;
        update_btb_info    = '0;
        update_hit         = 1'b0;
        update_hit_way     = 1'b0;
        repeat (16) @(posedge CLK);
        #1;
        rst = 1'b0;
        next_cycle();
        test_reset_reads();
        test_plru_victim();
        test_lane_match();
        test_double_hit();
        test_asid();
        test_none_and_rewrite();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
